// File: logic/pipe_pkg.sv
/* pipe control package
   widths, exception codes and the stage records of the scalar commit pipe */
package pipe_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int XLEN      = 32;  // data and pc
    localparam int REG_IDX_W = 5;
    localparam int RD_LSB    = 7;   // rd field in the opcode
    localparam int RD_MSB    = 11;
    localparam int EXC_W     = 6;

    // --------------------
    // exception codes
    // --------------------
    localparam logic [EXC_W-1:0] EXC_NONE             = 6'h00;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_FETCH = 6'h10;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_LOAD  = 6'h14;
    localparam logic [EXC_W-1:0] EXC_FAULT_LOAD       = 6'h15;
    localparam logic [EXC_W-1:0] EXC_MISALIGNED_STORE = 6'h16;
    localparam logic [EXC_W-1:0] EXC_FAULT_STORE      = 6'h17;
    localparam logic [EXC_W-1:0] EXC_PAGE_FAULT_LOAD  = 6'h1d;
    localparam logic [EXC_W-1:0] EXC_PAGE_FAULT_STORE = 6'h1f;

    // instruction class, decoded once at issue
    typedef struct packed {
        logic alu;
        logic load;
        logic store;
        logic mul;
        logic branch;
        logic rd_valid;
    } ctrl_t;

    // issue request from the front end
    typedef struct packed {
        logic             valid;
        logic             accept;
        logic             lsu;
        logic             mul;
        logic             branch;
        logic             rd_valid;
        logic             branch_taken;
        logic [XLEN-1:0]  branch_target;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  opcode;
        logic [XLEN-1:0]  operand_ra;
        logic [XLEN-1:0]  operand_rb;
        logic [EXC_W-1:0] exception;
    } issue_t;

    // one in-flight instruction
    typedef struct packed {
        logic             valid;
        ctrl_t            ctrl;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  opcode;
        logic [XLEN-1:0]  operand_ra;
        logic [XLEN-1:0]  operand_rb;
        logic [EXC_W-1:0] exception;
        logic [XLEN-1:0]  result;
    } stage_t;

    // writeback to the register file and trap logic
    typedef struct packed {
        logic                 valid;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      result;
        logic [XLEN-1:0]      pc;
        logic [EXC_W-1:0]     exception;
    } commit_t;

endpackage

// File: logic/issue_stage.sv
/* issue stage (E1)
   captures an accepted instruction, decodes its class and flags a misaligned
   branch target */
`timescale 1ns/100ps

module issue_stage
    import pipe_pkg::*;
(
    input  logic   clk_i,
    input  logic   rst_i,
    input  issue_t issue_i,
    input  logic   stall_i,
    input  logic   squash_i,
    output stage_t e1_o
);

    stage_t           e1_q;
    stage_t           e1_d;
    ctrl_t            ctrl_w;
    logic             take_w;
    logic             misaligned_w;
    logic [EXC_W-1:0] exc_w;

    // no take while the back end is flushing
    assign take_w       = issue_i.valid & issue_i.accept & ~squash_i;
    assign misaligned_w = issue_i.branch_taken & (issue_i.branch_target[1:0] != 2'b00);

    // --------------------
    // class decode
    // --------------------
    always_comb
    begin
        ctrl_w.alu      = ~(issue_i.lsu | issue_i.mul);
        ctrl_w.load     = issue_i.lsu & issue_i.rd_valid;
        ctrl_w.store    = issue_i.lsu & ~issue_i.rd_valid;  // no rd means store
        ctrl_w.mul      = issue_i.mul;
        ctrl_w.branch   = issue_i.branch;
        ctrl_w.rd_valid = issue_i.rd_valid;
    end

    // front end fault wins over the branch check
    always_comb
    begin
        if (|issue_i.exception)
            exc_w = issue_i.exception;
        else if (misaligned_w)
            exc_w = EXC_MISALIGNED_FETCH;
        else
            exc_w = EXC_NONE;
    end

    always_comb
    begin
        e1_d = '0;  // bubble by default
        if (take_w)
        begin
            e1_d.valid      = 1'b1;
            e1_d.ctrl       = ctrl_w;
            e1_d.pc         = issue_i.pc;
            e1_d.opcode     = issue_i.opcode;
            e1_d.operand_ra = issue_i.operand_ra;
            e1_d.operand_rb = issue_i.operand_rb;
            e1_d.exception  = exc_w;
            e1_d.result     = '0;  // filled in by E2 from the alu
        end
    end

    // --------------------
    // E1 register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            e1_q <= '0;
        else if (!stall_i)
            e1_q <= e1_d;
    end

    assign e1_o = e1_q;

endmodule

// File: logic/exec_stage.sv
/* execute stage (E2)
   picks the result, bypasses memory and multiply data, merges the memory
   exception and produces the pipe stall and squash */
`timescale 1ns/100ps

module exec_stage
    import pipe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  stage_t           e1_i,
    input  logic [XLEN-1:0]  alu_result_e1_i,
    input  logic             mem_complete_i,
    input  logic [XLEN-1:0]  mem_result_e2_i,
    input  logic [EXC_W-1:0] mem_exception_e2_i,
    input  logic [XLEN-1:0]  mul_result_e2_i,
    output stage_t           e2_o,
    output logic [EXC_W-1:0] e2_exception_o,
    output logic             stall_o,
    output logic             squash_o
);

    stage_t           e2_q;
    logic             ls_e2_w;
    logic             valid_e2_w;
    logic             squash_w;
    logic             squash_q;
    logic [XLEN-1:0]  result_r;
    logic [EXC_W-1:0] exc_r;

    // --------------------
    // E2 register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            e2_q <= '0;
        else if (!stall_o)
        begin
            if (squash_o)
                e2_q <= '0;  // flush
            else
            begin
                e2_q        <= e1_i;
                e2_q.result <= alu_result_e1_i;
                // faulted in E1, keep the code but drop the instruction
                if (|e1_i.exception)
                    e2_q.valid <= 1'b0;
            end
        end
    end

    assign ls_e2_w    = e2_q.ctrl.load | e2_q.ctrl.store;
    assign stall_o    = ls_e2_w & ~mem_complete_i;  // waiting on memory
    assign valid_e2_w = e2_q.valid & ~stall_o;

    // result select with late bypass
    always_comb
    begin
        result_r = e2_q.result;
        if (valid_e2_w && ls_e2_w)
            result_r = mem_result_e2_i;
        else if (valid_e2_w && e2_q.ctrl.mul)
            result_r = mul_result_e2_i;
    end

    // memory fault only counts once the access has returned
    always_comb
    begin
        if (e2_q.valid && ls_e2_w && mem_complete_i)
            exc_r = mem_exception_e2_i;
        else
            exc_r = e2_q.exception;
    end

    // --------------------
    // squash
    // --------------------
    assign squash_w = |exc_r;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            squash_q <= 1'b0;
        else if (!stall_o)
            squash_q <= squash_w;  // one extra cycle of flush
    end

    assign squash_o = squash_w | squash_q;

    always_comb
    begin
        e2_o        = e2_q;
        e2_o.result = result_r;
    end

    assign e2_exception_o = exc_r;

endmodule

// File: logic/commit_stage.sv
/* writeback stage
   latches the E2 instruction and gates commit valid and destination */
`timescale 1ns/100ps

module commit_stage
    import pipe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  stage_t           e2_i,
    input  logic [EXC_W-1:0] e2_exception_i,
    input  logic             stall_i,
    output commit_t          commit_o
);

    stage_t wb_q;
    logic   mem_fault_w;
    logic   valid_wb_w;

    // memory side faults never retire
    always_comb
    begin
        case (e2_exception_i)
            EXC_MISALIGNED_LOAD,
            EXC_FAULT_LOAD,
            EXC_MISALIGNED_STORE,
            EXC_FAULT_STORE,
            EXC_PAGE_FAULT_LOAD,
            EXC_PAGE_FAULT_STORE: mem_fault_w = 1'b1;
            default:              mem_fault_w = 1'b0;
        endcase
    end

    // --------------------
    // WB register
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            wb_q <= '0;
        else if (!stall_i)
        begin
            wb_q               <= e2_i;
            wb_q.valid         <= e2_i.valid & ~mem_fault_w;
            wb_q.ctrl.rd_valid <= e2_i.ctrl.rd_valid & ~(|e2_exception_i);  // no write on trap
            wb_q.exception     <= e2_exception_i;
        end
    end

    assign valid_wb_w = wb_q.valid & ~stall_i;

    always_comb
    begin
        commit_o.valid     = valid_wb_w;
        commit_o.rd        = (valid_wb_w && wb_q.ctrl.rd_valid) ?
                             wb_q.opcode[RD_MSB:RD_LSB] : '0;
        commit_o.result    = wb_q.result;
        commit_o.pc        = wb_q.pc;
        commit_o.exception = wb_q.exception;
    end

endmodule

// File: logic/pipe_ctrl.sv
/* pipe controller top
   issue, execute and writeback stages of the scalar commit pipe */
`timescale 1ns/100ps

module pipe_ctrl
    import pipe_pkg::*;
(
    input  logic             clk_i,
    input  logic             rst_i,
    input  issue_t           issue_i,
    input  logic [XLEN-1:0]  alu_result_e1_i,
    input  logic             mem_complete_i,
    input  logic [XLEN-1:0]  mem_result_e2_i,
    input  logic [EXC_W-1:0] mem_exception_e2_i,
    input  logic [XLEN-1:0]  mul_result_e2_i,
    output logic             load_e1_o,
    output logic             store_e1_o,
    output logic             mul_e1_o,
    output logic             branch_e1_o,
    output commit_t          commit_o,
    output logic             stall_o,
    output logic             squash_o
);

    stage_t           e1_w;
    stage_t           e2_w;
    logic [EXC_W-1:0] e2_exc_w;
    logic             stall_w;   // freezes every stage
    logic             squash_w;

    issue_stage u_issue (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .issue_i  (issue_i),
        .stall_i  (stall_w),
        .squash_i (squash_w),
        .e1_o     (e1_w)
    );

    exec_stage u_exec (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .e1_i               (e1_w),
        .alu_result_e1_i    (alu_result_e1_i),
        .mem_complete_i     (mem_complete_i),
        .mem_result_e2_i    (mem_result_e2_i),
        .mem_exception_e2_i (mem_exception_e2_i),
        .mul_result_e2_i    (mul_result_e2_i),
        .e2_o               (e2_w),
        .e2_exception_o     (e2_exc_w),
        .stall_o            (stall_w),
        .squash_o           (squash_w)
    );

    commit_stage u_commit (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .e2_i           (e2_w),
        .e2_exception_i (e2_exc_w),
        .stall_i        (stall_w),
        .commit_o       (commit_o)
    );

    // E1 status for the load/store and multiply units
    assign load_e1_o   = e1_w.ctrl.load;
    assign store_e1_o  = e1_w.ctrl.store;
    assign mul_e1_o    = e1_w.ctrl.mul;
    assign branch_e1_o = e1_w.ctrl.branch;

    assign stall_o  = stall_w;
    assign squash_o = squash_w;

endmodule

// File: include/pipe_ctrl_checks.svh
/* pipe controller checks
   typed compare tasks and pass/fail counters for the testbench */
`ifndef PIPE_CTRL_CHECKS_SVH
`define PIPE_CTRL_CHECKS_SVH

int pass_cnt = 0;
int fail_cnt = 0;

// whole commit record with a field report on mismatch
task automatic check_commit(input string tag, input pipe_pkg::commit_t got,
                            input pipe_pkg::commit_t exp);
    if (got === exp)
        pass_cnt++;
    else
    begin
        fail_cnt++;
        $display("FAILED %s commit_o: valid %h/%h rd %h/%h result %h/%h pc %h/%h exc %h/%h",
                 tag, got.valid, exp.valid, got.rd, exp.rd, got.result, exp.result,
                 got.pc, exp.pc, got.exception, exp.exception);
    end
endtask

task automatic check_flag(input string tag, input logic got, input logic exp);
    if (got === exp)
        pass_cnt++;
    else
    begin
        fail_cnt++;
        $display("FAILED %s: got %h expected %h", tag, got, exp);
    end
endtask

task automatic check_exc(input string tag, input logic [pipe_pkg::EXC_W-1:0] got,
                         input logic [pipe_pkg::EXC_W-1:0] exp);
    if (got === exp)
        pass_cnt++;
    else
    begin
        fail_cnt++;
        $display("FAILED %s commit_o.exception: got %h expected %h", tag, got, exp);
    end
endtask

`endif

// File: test/pipe_ctrl_tb.sv
/* pipe controller testbench
   runs a table of issue rows through the pipe and checks stall, squash and commit */
`timescale 1ns/100ps

module pipe_ctrl_tb
    import pipe_pkg::*;
;
    localparam int NROWS       = 11;
    localparam int RESET_CYC   = 10;
    localparam int TIMEOUT_CYC = NROWS * 12 + RESET_CYC;
    localparam logic [1:0] SRC_ALU = 2'd0;
    localparam logic [1:0] SRC_MEM = 2'd1;
    localparam logic [1:0] SRC_MUL = 2'd2;

    // one table row of stimulus and expected commit
    typedef struct packed {
        logic             lsu;
        logic             mul;
        logic             branch;
        logic             rd_valid;
        logic             taken;
        logic [XLEN-1:0]  target;
        logic [EXC_W-1:0] issue_exc;
        logic [EXC_W-1:0] mem_exc;
        logic [3:0]       waits;      // mem-wait cycles in E2
        logic             b2b;        // issued right behind the row before
        logic             exp_valid;
        logic [EXC_W-1:0] exp_exc;
        logic             exp_rd;
        logic [1:0]       exp_src;
    } row_t;

    logic             clk_i = 1'b0;
    logic             rst_i;
    issue_t           issue_i;
    logic [XLEN-1:0]  alu_result_e1_i;
    logic             mem_complete_i;
    logic [XLEN-1:0]  mem_result_e2_i;
    logic [EXC_W-1:0] mem_exception_e2_i;
    logic [XLEN-1:0]  mul_result_e2_i;
    logic             load_e1_o;
    logic             store_e1_o;
    logic             mul_e1_o;
    logic             branch_e1_o;
    commit_t          commit_o;
    logic             stall_o;
    logic             squash_o;

    row_t            tbl [NROWS];
    string           names [NROWS];
    logic [3:0]      e1_cls_q [NROWS];  // expected load, store, mul, branch in E1
    logic [XLEN-1:0] opcode_q [NROWS];
    logic [XLEN-1:0] ra_q [NROWS];
    logic [XLEN-1:0] rb_q [NROWS];
    logic [XLEN-1:0] alu_q [NROWS];
    logic [XLEN-1:0] mem_q [NROWS];
    logic [XLEN-1:0] mul_q [NROWS];
    int              seed = 32'haded_830e;
    int              cycle_cnt = 0;

    `include "pipe_ctrl_checks.svh"

    pipe_ctrl DUT (.*);

    always #50 clk_i = ~clk_i;

    // run limit
    always @(posedge clk_i)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC)
        begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYC);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic row_t make_row(input logic lsu, mul, br, rdv, tk,
                                      input logic [XLEN-1:0] tgt,
                                      input logic [EXC_W-1:0] iexc, mexc,
                                      input logic [3:0] w, input logic b2b, ev,
                                      input logic [EXC_W-1:0] eexc,
                                      input logic erd, input logic [1:0] src);
        row_t r;
        r = {lsu, mul, br, rdv, tk, tgt, iexc, mexc, w, b2b, ev, eexc, erd, src};
        return r;
    endfunction

    function automatic issue_t build_issue(input int i);
        issue_t r;
        r               = '0;
        r.valid         = 1'b1;
        r.accept        = 1'b1;
        r.lsu           = tbl[i].lsu;
        r.mul           = tbl[i].mul;
        r.branch        = tbl[i].branch;
        r.rd_valid      = tbl[i].rd_valid;
        r.branch_taken  = tbl[i].taken;
        r.branch_target = tbl[i].target;
        r.pc            = 32'h0000_1000 + i * 16;
        r.opcode        = opcode_q[i];
        r.operand_ra    = ra_q[i];
        r.operand_rb    = rb_q[i];
        r.exception     = tbl[i].issue_exc;
        return r;
    endfunction

    // squashed rows leave an all-zero writeback
    function automatic commit_t expected_commit(input int i);
        commit_t c;
        c = '0;
        if (!tbl[i].b2b)
        begin
            c.valid     = tbl[i].exp_valid;
            c.rd        = tbl[i].exp_rd ? opcode_q[i][RD_MSB:RD_LSB] : '0;
            c.result    = (tbl[i].exp_src == SRC_MEM) ? mem_q[i] :
                          (tbl[i].exp_src == SRC_MUL) ? mul_q[i] : alu_q[i];
            c.pc        = 32'h0000_1000 + i * 16;
            c.exception = tbl[i].exp_exc;
        end
        return c;
    endfunction

    task automatic report_row(input int i, input int fails_before);
        if (fail_cnt == fails_before)
            $display("row %0d %s: ok", i, names[i]);
        else
            $display("row %0d %s: %0d check(s) wrong", i, names[i], fail_cnt - fails_before);
    endtask

    task automatic run_row(input int i);
        int      w;
        int      k;
        int      fails_before;
        logic    follow;
        commit_t exp_c;
        fails_before = fail_cnt;
        w            = tbl[i].waits;
        follow       = (i + 1 < NROWS) && tbl[i + 1].b2b;
        exp_c        = expected_commit(i);
        @(posedge clk_i);
        issue_i            <= build_issue(i);
        alu_result_e1_i    <= alu_q[i];
        mem_result_e2_i    <= mem_q[i];
        mul_result_e2_i    <= mul_q[i];
        mem_exception_e2_i <= tbl[i].mem_exc;
        mem_complete_i     <= (w == 0);
        @(posedge clk_i);  // taken into E1
        if (follow)
            issue_i <= build_issue(i + 1);
        else
            issue_i.valid <= 1'b0;
        @(negedge clk_i);
        check_flag($sformatf("row %0d load_e1_o", i), load_e1_o, e1_cls_q[i][3]);
        check_flag($sformatf("row %0d store_e1_o", i), store_e1_o, e1_cls_q[i][2]);
        check_flag($sformatf("row %0d mul_e1_o", i), mul_e1_o, e1_cls_q[i][1]);
        check_flag($sformatf("row %0d branch_e1_o", i), branch_e1_o, e1_cls_q[i][0]);
        @(posedge clk_i);  // into E2
        issue_i.valid <= 1'b0;
        for (k = 0; k < w; k++)
        begin
            @(negedge clk_i);
            check_flag($sformatf("row %0d stall_o wait", i), stall_o, 1'b1);
            check_flag($sformatf("row %0d squash_o wait", i), squash_o, 1'b0);
            @(posedge clk_i);
            if (k == w - 1)
                mem_complete_i <= 1'b1;  // memory returns
        end
        @(negedge clk_i);
        check_flag($sformatf("row %0d stall_o", i), stall_o, 1'b0);
        check_flag($sformatf("row %0d squash_o", i), squash_o, |tbl[i].exp_exc);
        @(posedge clk_i);  // into writeback
        @(negedge clk_i);
        check_commit($sformatf("row %0d", i), commit_o, exp_c);
        check_exc($sformatf("row %0d", i), commit_o.exception, exp_c.exception);
        report_row(i, fails_before);
        if (follow)
        begin
            fails_before = fail_cnt;
            @(posedge clk_i);
            @(negedge clk_i);
            check_commit($sformatf("row %0d", i + 1), commit_o, expected_commit(i + 1));
            report_row(i + 1, fails_before);
        end
        repeat (4 + w) @(posedge clk_i);
    endtask

    // --------------------
    // stimulus
    // --------------------
    initial
    begin
        int i;
        rst_i              = 1'b1;
        issue_i            = '0;
        alu_result_e1_i    = '0;
        mem_complete_i     = 1'b1;
        mem_result_e2_i    = '0;
        mem_exception_e2_i = EXC_NONE;
        mul_result_e2_i    = '0;
        //                  lsu mul br rdv tk target        iexc   mexc  w b2b v exc   rd src
        tbl[0]  = make_row(0, 0, 0, 1, 0, 32'h0,         6'h00, 6'h00, 0, 0, 1, 6'h00, 1, SRC_ALU);
        tbl[1]  = make_row(1, 0, 0, 0, 0, 32'h0,         6'h00, 6'h00, 0, 0, 1, 6'h00, 0, SRC_MEM);
        tbl[2]  = make_row(1, 0, 0, 1, 0, 32'h0,         6'h00, 6'h00, 3, 0, 1, 6'h00, 1, SRC_MEM);
        tbl[3]  = make_row(0, 1, 0, 1, 0, 32'h0,         6'h00, 6'h00, 0, 0, 1, 6'h00, 1, SRC_MUL);
        tbl[4]  = make_row(0, 0, 1, 0, 1, 32'h0000_2000, 6'h00, 6'h00, 0, 0, 1, 6'h00, 0, SRC_ALU);
        tbl[5]  = make_row(0, 0, 1, 1, 1, 32'h0000_2002, 6'h00, 6'h00, 0, 0, 0, 6'h10, 0, SRC_ALU);
        tbl[6]  = make_row(0, 0, 0, 1, 0, 32'h0,         6'h01, 6'h00, 0, 0, 0, 6'h01, 0, SRC_ALU);
        tbl[7]  = make_row(1, 0, 0, 1, 0, 32'h0,         6'h00, 6'h15, 0, 0, 0, 6'h15, 0, SRC_MEM);
        tbl[8]  = make_row(0, 0, 0, 1, 0, 32'h0,         6'h00, 6'h00, 0, 1, 0, 6'h00, 0, SRC_ALU);
        tbl[9]  = make_row(1, 0, 0, 0, 0, 32'h0,         6'h00, 6'h1f, 2, 0, 0, 6'h1f, 0, SRC_MEM);
        tbl[10] = make_row(0, 0, 0, 1, 0, 32'h0,         6'h00, 6'h15, 0, 0, 1, 6'h00, 1, SRC_ALU);
        names = '{"alu", "store", "load wait", "mul", "branch", "branch misaligned",
                  "issue exc", "load fault", "squashed alu", "store page fault", "alu"};
        e1_cls_q = '{4'b0000, 4'b0100, 4'b1000, 4'b0010, 4'b0001, 4'b0001,
                     4'b0000, 4'b1000, 4'b0000, 4'b0100, 4'b0000};
        for (i = 0; i < NROWS; i++)
        begin
            opcode_q[i] = $random(seed);
            ra_q[i]     = $random(seed);
            rb_q[i]     = $random(seed);
            alu_q[i]    = $random(seed);
            mem_q[i]    = $random(seed);
            mul_q[i]    = $random(seed);
        end
        repeat (RESET_CYC) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_flag("reset commit_o.valid", commit_o.valid, 1'b0);
        check_flag("reset stall_o", stall_o, 1'b0);
        check_flag("reset squash_o", squash_o, 1'b0);
        if (fail_cnt == 0)
            $display("reset: ok");
        else
            $display("reset: %0d check(s) wrong", fail_cnt);
        for (i = 0; i < NROWS; i++)
        begin
            if (tbl[i].b2b)
                continue;  // issued with the row before
            run_row(i);
        end
        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
logic/pipe_pkg.sv
logic/issue_stage.sv
logic/exec_stage.sv
logic/commit_stage.sv
logic/pipe_ctrl.sv
test/pipe_ctrl_tb.sv
